//--- list.f
src/bus_pkg.sv
src/io_pkg.sv
src/debounce_tick.sv
src/debounce_filter.sv
src/gpio_bank.sv
src/bus_slave_fsm.sv
src/gpio_subsystem.sv
tb/gpio_subsystem_properties.sv
tb/tb_gpio_subsystem.sv

//--- Makefile
# Verilator build and run of the GPIO subsystem testbench

TOP = tb_gpio_subsystem

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f list.f -o $(TOP)

# The run passes only if the pass message shows up in the output
run: compile
	@out="$$(./obj_dir/$(TOP) +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf obj_dir

//--- tb/tb_gpio_subsystem.sv
//********************
// GPIO subsystem testbench
// Random bus and pad stimulus checked against a reference model
//********************

`default_nettype none
`timescale 1ns/1ps

module tb_gpio_subsystem
   import bus_pkg::*;
   import io_pkg::*;
();

   localparam int TICK_DIV = 4;
   localparam int DB_DEPTH = 3;
   localparam int TIMEOUT  = 20;                       // Cycles allowed for ack
   localparam int SETTLE   = DB_DEPTH * TICK_DIV + 4;

   logic                clk;
   logic                rst_n;
   logic                bus_cyc;
   logic                bus_stb;
   logic                bus_we;
   logic [BUS_AW-1:0]   bus_adr;
   bus_data_t           bus_dat;
   bus_data_t           bus_rdt;
   logic                bus_ack;
   gpio_t [N_BANKS-1:0] gpio_in;
   gpio_t [N_BANKS-1:0] gpio_out;
   gpio_t [N_BANKS-1:0] gpio_oe;
   sw_t                 sw;
   btn_t                btn;

   // Reference model of OUT, OE and the settled debounced bits
   gpio_t m_out [N_BANKS];
   gpio_t m_oe  [N_BANKS];
   sw_t   m_sw_db;
   btn_t  m_btn_db;

   logic [31:0] lfsr = 32'd36;
   int          errors = 0;
   int          test_errors;
   int          n_tests = 0;
   string       test_name;

   gpio_subsystem #(.TICK_DIV(TICK_DIV), .DB_DEPTH(DB_DEPTH)) DUT (
      .clk (clk), .i_rst_n (rst_n),
      .i_bus_cyc (bus_cyc), .i_bus_stb (bus_stb), .i_bus_we (bus_we),
      .i_bus_adr (bus_adr), .i_bus_dat (bus_dat),
      .i_gpio (gpio_in), .i_sw (sw), .i_btn (btn),
      .o_bus_rdt (bus_rdt), .o_bus_ack (bus_ack),
      .o_gpio (gpio_out), .o_gpio_oe (gpio_oe)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   initial begin
      #200_000;
      $display("Simulation did not complete within the time limit");
      $display("** FAIL **");
      $finish;
   end

   //********************
   // Helpers
   //********************
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hD000_0001) : (lfsr >> 1);   // Galois step
         v    = {v[30:0], lfsr[0]};
      end
      return v;
   endfunction

   function automatic logic [BUS_AW-1:0] reg_addr(input logic b, input reg_sel_t sel);
      return {b, sel};
   endfunction

   // Switches sit on top of bank 0, buttons at the bottom of bank 1
   function automatic gpio_t expected_in(input logic b);
      if (!b) return {m_sw_db, gpio_in[0][GPIO_W-SW_W-1:0]};
      return {gpio_in[1][GPIO_W-1:BTN_W], m_btn_db};
   endfunction

   task automatic check(input logic [31:0] exp, input logic [31:0] act);
      if (exp !== act) begin
         $display("MISMATCH %s: expected %h, actual %h", test_name, exp, act);
         errors++;
         test_errors++;
      end
   endtask

   task automatic begin_test(input string name);
      test_name   = name;
      test_errors = 0;
   endtask

   task automatic end_test();
      n_tests++;
      $display("test %s finished with %0d error(s)", test_name, test_errors);
   endtask

   task automatic bus_cycle(input logic we, input logic [BUS_AW-1:0] adr,
                            input bus_data_t wdat, output bus_data_t rdat);
      int waited;
      waited  = 0;
      rdat    = '0;
      bus_cyc = 1'b1;
      bus_stb = 1'b1;
      bus_we  = we;
      bus_adr = adr;
      bus_dat = wdat;
      do begin
         @(negedge clk);
         waited++;
      end while (!bus_ack && waited < TIMEOUT);
      if (bus_ack) begin
         rdat = bus_rdt;
      end else begin
         $display("Bus access to address %0d got no ack within %0d cycles", adr, TIMEOUT);
         errors++;
         test_errors++;
      end
      bus_cyc = 1'b0;   // Drop strobes once ack is seen
      bus_stb = 1'b0;
      bus_we  = 1'b0;
   endtask

   task automatic bus_write(input logic [BUS_AW-1:0] adr, input bus_data_t wdat);
      bus_data_t unused;
      bus_cycle(1'b1, adr, wdat, unused);
   endtask

   task automatic bus_read(input logic [BUS_AW-1:0] adr, output bus_data_t rdat);
      bus_cycle(1'b0, adr, '0, rdat);
   endtask

   task automatic read_check(input logic b, input reg_sel_t sel, input bus_data_t exp);
      bus_data_t rd;
      bus_read(reg_addr(b, sel), rd);
      check(exp, rd);
   endtask

   task automatic check_outputs();
      check(m_out[0], gpio_out[0]);
      check(m_oe[0], gpio_oe[0]);
      check(m_out[1], gpio_out[1]);
      check(m_oe[1], gpio_oe[1]);
   endtask

   task automatic check_inputs();
      read_check(1'b0, REG_IN, expected_in(1'b0));
      read_check(1'b1, REG_IN, expected_in(1'b1));
   endtask

   //********************
   // Test sequence
   //********************
   initial begin
      bus_data_t   wd;
      logic        b;
      logic        glitch_sw;
      reg_sel_t    sel;
      int unsigned n_assert;
      rst_n   = 1'b0;
      bus_cyc = 1'b0;
      bus_stb = 1'b0;
      bus_we  = 1'b0;
      bus_adr = '0;
      bus_dat = '0;
      gpio_in = '0;
      sw      = '0;
      btn     = '0;
      m_out   = '{default: '0};
      m_oe    = '{default: '0};
      m_sw_db  = '0;
      m_btn_db = '0;
      repeat (3) @(negedge clk);
      rst_n = 1'b1;
      @(negedge clk);

      begin_test("reset");
      check(32'd0, 32'(bus_ack));
      check_outputs();
      read_check(1'b0, REG_OUT, '0);
      read_check(1'b0, REG_OE, '0);
      read_check(1'b1, REG_OUT, '0);
      read_check(1'b1, REG_OE, '0);
      end_test();

      begin_test("out_regs");
      for (int n = 0; n < 24; n++) begin
         b   = 1'(rand_bits(1));
         sel = reg_sel_t'(rand_bits(2));   // IN and offset 3 must ignore writes
         wd  = rand_bits(BUS_DW);
         bus_write(reg_addr(b, sel), wd);
         if (sel == REG_OUT) m_out[b] = wd;
         else if (sel == REG_OE) m_oe[b] = wd;
         check_outputs();
         read_check(b, REG_OUT, m_out[b]);
         read_check(b, REG_OE, m_oe[b]);
      end
      bus_write(reg_addr(1'b0, reg_sel_t'(3)), rand_bits(BUS_DW));
      bus_write(reg_addr(1'b1, reg_sel_t'(3)), rand_bits(BUS_DW));
      check_outputs();
      read_check(1'b0, reg_sel_t'(3), '0);
      read_check(1'b1, reg_sel_t'(3), '0);
      end_test();

      begin_test("raw_inputs");
      for (int n = 0; n < 8; n++) begin
         gpio_in[0] = rand_bits(GPIO_W);
         gpio_in[1] = rand_bits(GPIO_W);
         repeat (3) @(negedge clk);
         check_inputs();
      end
      end_test();

      begin_test("debounce");
      for (int n = 0; n < 4; n++) begin
         sw  = sw_t'(rand_bits(SW_W));
         btn = btn_t'(rand_bits(BTN_W));
         repeat (SETTLE) @(negedge clk);
         m_sw_db  = sw;
         m_btn_db = btn;
         check_inputs();
      end
      end_test();

      begin_test("glitch");
      for (int n = 0; n < 6; n++) begin
         glitch_sw = 1'(rand_bits(1));
         if (glitch_sw) sw = ~sw;
         else btn = ~btn;
         repeat (TICK_DIV - 1) @(negedge clk);   // Short of one tick period
         sw  = m_sw_db;
         btn = m_btn_db;
         @(negedge clk);
         // Glitched bank first, while a passed pulse would still show
         read_check(!glitch_sw, REG_IN, expected_in(!glitch_sw));
         repeat (SETTLE) @(negedge clk);
         check_inputs();
      end
      end_test();

      n_assert = DUT.u_props.n_fail;
      $display("%0d tests run, %0d errors, %0d assertion failures", n_tests, errors, n_assert);
      if (errors == 0 && n_assert == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- tb/gpio_subsystem_properties.sv
//********************
// Bus strobe and reset assertions, bound to the GPIO subsystem
//********************

`default_nettype none
`timescale 1ns/1ps

module gpio_subsystem_properties
   import io_pkg::*;
(
   input logic                clk,
   input logic                i_rst_n,
   input logic                i_cyc,
   input logic                i_stb,
   input logic                i_ack,
   input gpio_t [N_BANKS-1:0] i_gpio,
   input gpio_t [N_BANKS-1:0] i_gpio_oe
);

   int unsigned n_fail = 0;   // Failed assertion count

   a_ack_single : assert property (@(posedge clk) disable iff (!i_rst_n)
      i_ack |=> !i_ack)
      else begin $error("ack stayed high for two cycles"); n_fail++; end

   a_ack_request : assert property (@(posedge clk) disable iff (!i_rst_n)
      i_ack |-> $past(i_cyc && i_stb))
      else begin $error("ack without a preceding cyc and stb"); n_fail++; end

   // Outputs clear in the first cycle out of reset
   a_reset_out : assert property (@(posedge clk)
      $rose(i_rst_n) |-> (i_gpio == '0) && (i_gpio_oe == '0))
      else begin $error("gpio outputs not zero after reset"); n_fail++; end

endmodule

bind gpio_subsystem gpio_subsystem_properties u_props (
   .clk       (clk),
   .i_rst_n   (i_rst_n),
   .i_cyc     (i_bus_cyc),
   .i_stb     (i_bus_stb),
   .i_ack     (o_bus_ack),
   .i_gpio    (o_gpio),
   .i_gpio_oe (o_gpio_oe)
);

`default_nettype wire

//--- src/gpio_subsystem.sv
//********************
// GPIO subsystem top level
// Two banks, switch and button debouncing, register bus slave
//********************

`default_nettype none
`timescale 1ns/1ps

module gpio_subsystem
   import bus_pkg::*;
   import io_pkg::*;
#(
   parameter int TICK_DIV = 1000,
   parameter int DB_DEPTH = 4
) (
   input  logic                    clk,
   input  logic                    i_rst_n,
   input  logic                    i_bus_cyc,
   input  logic                    i_bus_stb,
   input  logic                    i_bus_we,
   input  logic [BUS_AW-1:0]       i_bus_adr,
   input  bus_data_t               i_bus_dat,
   input  gpio_t [N_BANKS-1:0]     i_gpio,
   input  sw_t                     i_sw,
   input  btn_t                    i_btn,
   output bus_data_t               o_bus_rdt,
   output logic                    o_bus_ack,
   output gpio_t [N_BANKS-1:0]     o_gpio,
   output gpio_t [N_BANKS-1:0]     o_gpio_oe
);

   logic                    tick;
   sw_t                     sw_db;
   btn_t                    btn_db;
   gpio_t [N_BANKS-1:0]     bank_in;
   bus_data_t [N_BANKS-1:0] bank_rdt;
   logic [N_BANKS-1:0]      bank_wr;
   reg_sel_t                reg_sel;
   bus_data_t               wdat;

   //********************
   // Debouncing
   //********************
   debounce_tick #(.TICK_DIV(TICK_DIV)) u_tick (
      .clk     (clk),
      .i_rst_n (i_rst_n),
      .o_tick  (tick)
   );

   debounce_filter #(.payload_t(sw_t), .DB_DEPTH(DB_DEPTH)) u_sw_filter (
      .clk     (clk),
      .i_rst_n (i_rst_n),
      .i_tick  (tick),
      .i_raw   (i_sw),
      .o_db    (sw_db)
   );

   debounce_filter #(.payload_t(btn_t), .DB_DEPTH(DB_DEPTH)) u_btn_filter (
      .clk     (clk),
      .i_rst_n (i_rst_n),
      .i_tick  (tick),
      .i_raw   (i_btn),
      .o_db    (btn_db)
   );

   // Switches on the upper half of bank 0, buttons on the low bits of bank 1
   assign bank_in[0] = {sw_db, i_gpio[0][GPIO_W-SW_W-1:0]};
   assign bank_in[1] = {i_gpio[1][GPIO_W-1:BTN_W], btn_db};

   //********************
   // Banks and bus slave
   //********************
   for (genvar b = 0; b < N_BANKS; b++) begin : g_bank
      gpio_bank u_bank (
         .clk       (clk),
         .i_rst_n   (i_rst_n),
         .i_wr      (bank_wr[b]),
         .i_reg_sel (reg_sel),
         .i_wdat    (wdat),
         .i_pad     (bank_in[b]),
         .o_rdt     (bank_rdt[b]),
         .o_out     (o_gpio[b]),
         .o_oe      (o_gpio_oe[b])
      );
   end

   bus_slave_fsm u_bus_fsm (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_bus_cyc  (i_bus_cyc),
      .i_bus_stb  (i_bus_stb),
      .i_bus_we   (i_bus_we),
      .i_bus_adr  (i_bus_adr),
      .i_bus_dat  (i_bus_dat),
      .i_bank_rdt (bank_rdt),
      .o_bank_wr  (bank_wr),
      .o_reg_sel  (reg_sel),
      .o_wdat     (wdat),
      .o_bus_rdt  (o_bus_rdt),
      .o_bus_ack  (o_bus_ack)
   );

endmodule

`default_nettype wire

//--- src/bus_slave_fsm.sv
//********************
// Register bus slave FSM
// Decodes the bank, strobes writes and returns read data with ack
//********************

`default_nettype none
`timescale 1ns/1ps

module bus_slave_fsm
   import bus_pkg::*;
   import io_pkg::*;
(
   input  logic                       clk,
   input  logic                       i_rst_n,
   input  logic                       i_bus_cyc,
   input  logic                       i_bus_stb,
   input  logic                       i_bus_we,
   input  logic [BUS_AW-1:0]          i_bus_adr,
   input  logic [BUS_DW-1:0]          i_bus_dat,
   input  bus_data_t [N_BANKS-1:0]    i_bank_rdt,
   output logic [N_BANKS-1:0]         o_bank_wr,
   output reg_sel_t                   o_reg_sel,
   output bus_data_t                  o_wdat,
   output bus_data_t                  o_bus_rdt,
   output logic                       o_bus_ack
);

   typedef enum logic {IDLE, ACK} state_t;

   state_t state_q;
   logic   accept;
   logic   bank_sel;

   assign accept   = (state_q == IDLE) && i_bus_cyc && i_bus_stb;
   assign bank_sel = i_bus_adr[BUS_AW-1];   // Upper address bit picks the bank

   // Selector and data go straight to the banks so the write
   // lands on the same edge that accepts the request
   assign o_reg_sel = i_bus_adr[1:0];
   assign o_wdat    = i_bus_dat;
   assign o_bank_wr = (accept && i_bus_we) ? (N_BANKS'(1) << bank_sel) : '0;

   assign o_bus_ack = (state_q == ACK);

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         state_q <= IDLE;
      end else begin
         case (state_q)
            IDLE: if (accept) state_q <= ACK;
            ACK:  state_q <= IDLE;   // Single ack cycle
            default: state_q <= IDLE;
         endcase
      end
   end

   // Read word held for the ack cycle
   always_ff @(posedge clk) begin
      if (accept) begin
         o_bus_rdt <= i_bank_rdt[bank_sel];
      end
   end

endmodule

`default_nettype wire

//--- src/gpio_bank.sv
//********************
// One GPIO bank
// Output, output enable and input sample registers with read mux
//********************

`default_nettype none
`timescale 1ns/1ps

module gpio_bank
   import bus_pkg::*;
   import io_pkg::*;
(
   input  logic      clk,
   input  logic      i_rst_n,
   input  logic      i_wr,
   input  reg_sel_t  i_reg_sel,
   input  bus_data_t i_wdat,
   input  gpio_t     i_pad,
   output bus_data_t o_rdt,
   output gpio_t     o_out,
   output gpio_t     o_oe
);

   gpio_t in_q;

   //********************
   // Writable registers
   //********************
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_out <= '0;
         o_oe  <= '0;
      end else if (i_wr) begin
         case (i_reg_sel)
            REG_OUT: o_out <= i_wdat;
            REG_OE:  o_oe  <= i_wdat;
            default: ;   // IN and offset 3 ignore writes
         endcase
      end
   end

   // Pad sample, one cycle behind the pins
   always_ff @(posedge clk) begin
      in_q <= i_pad;
   end

   //********************
   // Read mux
   //********************
   always_comb begin
      case (i_reg_sel)
         REG_IN:  o_rdt = in_q;
         REG_OUT: o_rdt = o_out;
         REG_OE:  o_rdt = o_oe;
         default: o_rdt = '0;
      endcase
   end

endmodule

`default_nettype wire

//--- src/debounce_filter.sv
//********************
// Per-bit stability filter, sampled on the debounce tick
//********************

`default_nettype none
`timescale 1ns/1ps

module debounce_filter #(
   parameter type payload_t = logic [7:0],
   parameter int  DB_DEPTH  = 4
) (
   input  logic     clk,
   input  logic     i_rst_n,
   input  logic     i_tick,
   input  payload_t i_raw,
   output payload_t o_db
);

   localparam int W     = $bits(payload_t);
   localparam int CNT_W = $clog2(DB_DEPTH + 1);

   logic [W-1:0]     raw_v;
   logic [W-1:0]     db_q;
   logic [CNT_W-1:0] cnt_q [W];   // Consecutive disagreeing ticks

   assign raw_v = i_raw;
   assign o_db  = payload_t'(db_q);

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         db_q <= '0;
         for (int i = 0; i < W; i++) begin
            cnt_q[i] <= '0;
         end
      end else if (i_tick) begin
         for (int i = 0; i < W; i++) begin
            if (raw_v[i] == db_q[i]) begin
               cnt_q[i] <= '0;
            end else if (cnt_q[i] == CNT_W'(DB_DEPTH - 1)) begin
               db_q[i]  <= raw_v[i];   // Stable for DB_DEPTH ticks
               cnt_q[i] <= '0;
            end else begin
               cnt_q[i] <= cnt_q[i] + 1'b1;
            end
         end
      end
   end

endmodule

`default_nettype wire

//--- src/debounce_tick.sv
//********************
// Debounce sampling tick prescaler
//********************

`default_nettype none
`timescale 1ns/1ps

module debounce_tick #(
   parameter int TICK_DIV = 1000
) (
   input  logic clk,
   input  logic i_rst_n,
   output logic o_tick
);

   localparam int CNT_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

   logic [CNT_W-1:0] cnt_q;

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         cnt_q  <= '0;
         o_tick <= 1'b0;
      end else if (cnt_q == CNT_W'(TICK_DIV - 1)) begin
         cnt_q  <= '0;
         o_tick <= 1'b1;   // One pulse per wrap
      end else begin
         cnt_q  <= cnt_q + 1'b1;
         o_tick <= 1'b0;
      end
   end

endmodule

`default_nettype wire

//--- src/io_pkg.sv
//********************
// Pad widths and payload types
//********************

`default_nettype none

package io_pkg;

   localparam int GPIO_W  = 32;   // Bank width
   localparam int SW_W    = 16;   // Slide switches
   localparam int BTN_W   = 5;    // Push buttons
   localparam int N_BANKS = 2;

   typedef logic [GPIO_W-1:0] gpio_t;
   typedef logic [SW_W-1:0]   sw_t;
   typedef logic [BTN_W-1:0]  btn_t;

endpackage

`default_nettype wire

//--- src/bus_pkg.sv
//********************
// Register bus widths, address layout and register offsets
//********************

`default_nettype none

package bus_pkg;

   // Bus data width
   localparam int BUS_DW = 32;

   // Word address: bit 2 selects the bank, bits 1..0 the register
   localparam int BUS_AW = 3;

   typedef logic [1:0]        reg_sel_t;
   typedef logic [BUS_DW-1:0] bus_data_t;

   //********************
   // Register offsets within a bank
   //********************
   localparam reg_sel_t REG_IN  = 2'd0;   // Sampled pads, read only
   localparam reg_sel_t REG_OUT = 2'd1;
   localparam reg_sel_t REG_OE  = 2'd2;
   // Offset 3 reads zero

endpackage

`default_nettype wire
